// File: dmem_top.f
verilog/dbus_pkg.sv
verilog/lsu_pkg.sv
verilog/dbus_mem.sv
verilog/lsu_align.sv
verilog/lsu_ctrl.sv
verilog/dmem_top.sv
bench/dmem_checker.sv
bench/dmem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := dmem_tb
FILELIST  := dmem_top.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Something failed
PASS_MSG  := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/dmem_tb.sv
`timescale 1ns/1ps

module dmem_tb
	import dbus_pkg::*;
	import lsu_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int NUM_FILL   = 256;
	localparam int NUM_RANDOM = 300;
	localparam int CMD_BUDGET = NUM_FILL + NUM_RANDOM + 150;  // Directed tests stay below 150.
	localparam int REF_BYTES  = 1024;

	logic     clk;
	logic     rst;
	logic     miss_model_en;
	logic     req;
	lsu_cmd_t cmd;
	logic     ack;
	lsu_rsp_t rsp;

	logic [7:0]  ref_mem [REF_BYTES];
	lsu_rsp_t    exp_q [$];
	logic [31:0] rng_state;
	logic        ack_q;

	dmem_top DUT (
		.clk           (clk),
		.rst           (rst),
		.miss_model_en (miss_model_en),
		.req           (req),
		.cmd           (cmd),
		.ack           (ack),
		.rsp           (rsp)
	);

	bind dmem_top dmem_checker u_checker (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.ack     (ack),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Odd multiplier, so every address bit changes the word.
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr * 32'h9E37_79B9 + 32'h0123_4567;
	endfunction

	// Little-endian byte memory; updates ref_mem for stores.
	function automatic lsu_rsp_t model_access(input lsu_cmd_t c);
		lsu_rsp_t    r;
		logic [9:0]  a;
		int          nbytes;
		logic [31:0] raw;
		r = '0;
		raw = '0;
		a = c.addr[9:0];
		case (c.op)
			LB, LBU, SB: nbytes = 1;
			LH, LHU, SH: nbytes = 2;
			default:     nbytes = 4;
		endcase
		if ((nbytes == 2 && a[0]) || (nbytes == 4 && a[1:0] != 2'b00)) begin
			r.misaligned = 1'b1;
			return r;
		end
		if (c.op inside {SB, SH, SW}) begin
			for (int i = 0; i < nbytes; i++) begin
				ref_mem[a + 10'(i)] = c.wdata[8*i +: 8];
			end
			return r;
		end
		for (int i = 0; i < nbytes; i++) begin
			raw[8*i +: 8] = ref_mem[a + 10'(i)];
		end
		case (c.op)
			LB:      r.rdata = {{24{raw[7]}}, raw[7:0]};
			LH:      r.rdata = {{16{raw[15]}}, raw[15:0]};
			default: r.rdata = raw;  // Zero extension comes from raw being cleared.
		endcase
		return r;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_rsp(input lsu_rsp_t got, input lsu_rsp_t exp);
		if (got.rdata !== exp.rdata) begin
			report_failure($sformatf("Mismatch at %0t: rsp.rdata got 0x%08h expected 0x%08h",
				$time, got.rdata, exp.rdata));
		end
		if (got.misaligned !== exp.misaligned) begin
			report_failure($sformatf("Mismatch at %0t: rsp.misaligned got %b expected %b",
				$time, got.misaligned, exp.misaligned));
		end
	endtask

	task automatic check_ack(input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("Mismatch at %0t: ack got %b expected %b", $time, got, exp));
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	endtask

	// One four-phase transfer; cycles counts from req to ack.
	task automatic run_cmd(input lsu_cmd_t c, output int cycles);
		exp_q.push_back(model_access(c));
		@(posedge clk);
		cmd <= c;
		req <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!ack);
		req <= 1'b0;
		do begin
			@(posedge clk);
		end while (ack);
	endtask

	task automatic send(input lsu_op_t op, input logic [31:0] addr, input logic [31:0] wdata);
		lsu_cmd_t c;
		int       cycles;
		c.op    = op;
		c.addr  = addr;
		c.wdata = wdata;
		run_cmd(c, cycles);
	endtask

	always @(posedge clk) begin
		if (ack && !ack_q) begin
			if (exp_q.size() == 0) begin
				report_failure("ack rose with no command outstanding");
			end else begin
				check_rsp(rsp, exp_q.pop_front());
			end
		end
		ack_q <= ack;
	end

	always @(posedge clk) begin
		if (DUT.u_checker.fail_count != 0) begin
			report_failure("A handshake or bus assertion failed in the checker");
		end
	end

	initial begin
		#(CMD_BUDGET * 20 * CLK_PERIOD);
		report_failure("Watchdog expired before the command sequence finished");
	end

	initial begin
		lsu_cmd_t    c;
		int          lat_miss;
		int          lat_hit;
		logic [31:0] r;
		rst           <= 1'b1;
		miss_model_en <= 1'b0;
		req           <= 1'b0;
		cmd           <= '0;
		rng_state     = 32'd7;
		apply_reset();
		@(posedge clk);
		check_ack(ack, 1'b0);

		send(SW, 32'h40, 32'hDEAD_BEEF);
		send(LW, 32'h40, 32'h0);

		for (int w = 0; w < NUM_FILL; w++) begin
			send(SW, w * 4, fill_word(w * 4));  // Random loads then never see unwritten words.
		end

		send(SW, 32'h80, 32'h1122_3344);
		send(SB, 32'h81, 32'hFFFF_FFAA);
		send(LW, 32'h80, 32'h0);
		send(SH, 32'h82, 32'hFFFF_BBCC);
		send(SB, 32'h80, 32'h1234_56EE);
		send(LW, 32'h80, 32'h0);
		send(SH, 32'h80, 32'hA5A5_1357);
		send(SB, 32'h83, 32'h0000_0099);
		send(LW, 32'h80, 32'h0);

		for (int p = 0; p < 2; p++) begin
			send(SW, 32'hC0, p == 0 ? 32'h807F_01FE : 32'h7F80_FE01);
			for (int k = 0; k < 4; k++) begin
				send(LB, 32'hC0 + k, 32'h0);
				send(LBU, 32'hC0 + k, 32'h0);
				if (k % 2 == 0) begin
					send(LH, 32'hC0 + k, 32'h0);
					send(LHU, 32'hC0 + k, 32'h0);
				end
			end
		end

		send(SW, 32'h100, 32'hCAFE_F00D);
		send(SH, 32'h101, 32'hFFFF_1234);
		send(SH, 32'h103, 32'hFFFF_5678);
		send(SW, 32'h101, 32'h0);
		send(SW, 32'h102, 32'h0);
		send(SW, 32'h103, 32'h0);
		send(LH, 32'h101, 32'h0);
		send(LHU, 32'h103, 32'h0);
		send(LW, 32'h102, 32'h0);
		send(LW, 32'h100, 32'h0);

		// Reset clears the touched lines but keeps memory contents.
		apply_reset();
		miss_model_en <= 1'b1;
		for (int n = 0; n < 4; n++) begin
			c.op    = LW;
			c.addr  = 32'h200 + n * 32'h40;
			c.wdata = '0;
			run_cmd(c, lat_miss);
			run_cmd(c, lat_hit);
			if (lat_miss <= lat_hit) begin
				report_failure($sformatf("First load to line at 0x%h was not slower than a repeat",
					c.addr));
			end
		end
		miss_model_en <= 1'b0;
		for (int n = 0; n < 4; n++) begin
			send(LW, 32'h200 + n * 32'h40, 32'h0);
			send(LH, 32'h202 + n * 32'h40, 32'h0);
		end

		apply_reset();
		for (int i = 0; i < NUM_RANDOM; i++) begin
			if (i % 50 == 0) begin
				miss_model_en <= ~miss_model_en;
			end
			r       = next_rand();
			c.op    = lsu_op_t'(r[2:0]);
			c.addr  = {22'b0, r[13:4]};
			c.wdata = next_rand();
			run_cmd(c, lat_miss);
		end

		repeat (2) @(posedge clk);
		if (exp_q.size() != 0) begin
			report_failure("A command ended without its response being checked");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

// File: bench/dmem_checker.sv
`timescale 1ns/1ps

module dmem_checker
	import dbus_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      req,
	input logic      ack,
	input dbus_req_t bus_req,
	input dbus_rsp_t bus_rsp
);

	int unsigned fail_count = 0;  // Read by the testbench.
	logic        staged_read;     // Shadow of the memory stage read flag.
	int unsigned stall_run;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			staged_read <= 1'b0;
			stall_run   <= 0;
		end else begin
			if (!bus_rsp.stall) begin
				staged_read <= bus_req.read;
			end
			stall_run <= bus_rsp.stall ? stall_run + 1 : 0;
		end
	end

	ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
		else begin
			$error("ack rose while req was low");
			fail_count = fail_count + 1;
		end

	ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
		else begin
			$error("ack fell while req was still high");
			fail_count = fail_count + 1;
		end

	stall_len: assert property (@(posedge clk) disable iff (rst)
		bus_rsp.stall |-> stall_run < MISS_CYCLES + 1)
		else begin
			$error("stall held longer than the miss window");
			fail_count = fail_count + 1;
		end

	stall_read: assert property (@(posedge clk) disable iff (rst) bus_rsp.stall |-> staged_read)
		else begin
			$error("stall high without a staged read");
			fail_count = fail_count + 1;
		end

	one_cycle: assert property (@(posedge clk) disable iff (rst)
		(bus_req.read || bus_req.write) |=> !(bus_req.read || bus_req.write))
		else begin
			$error("bus request held for more than one cycle");
			fail_count = fail_count + 1;
		end

endmodule

// File: verilog/dmem_top.sv
`timescale 1ns/1ps

module dmem_top
	import dbus_pkg::*;
	import lsu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     miss_model_en,
	input  logic     req,
	input  lsu_cmd_t cmd,
	output logic     ack,
	output lsu_rsp_t rsp
);

	dbus_req_t bus_req;
	dbus_rsp_t bus_rsp;

	lsu_ctrl u_lsu_ctrl (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.cmd     (cmd),
		.ack     (ack),
		.rsp     (rsp),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp)
	);

	// Behavioral memory with the miss stall model.
	dbus_mem u_dbus_mem (
		.clk           (clk),
		.rst           (rst),
		.miss_model_en (miss_model_en),
		.bus_req       (bus_req),
		.bus_rsp       (bus_rsp)
	);

endmodule

// File: verilog/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl
	import dbus_pkg::*;
	import lsu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      req,
	input  lsu_cmd_t  cmd,
	output logic      ack,
	output lsu_rsp_t  rsp,
	output dbus_req_t bus_req,
	input  dbus_rsp_t bus_rsp
);

	typedef enum logic [2:0] {
		IDLE,
		ISSUE,
		WAIT,
		DONE,
		ERROR
	} state_t;

	state_t                state;
	lsu_cmd_t              cmd_q;
	dbus_req_t             req_fields;
	logic                  misaligned;
	logic [DATA_WIDTH-1:0] load_data;
	logic                  access;
	logic                  bus_done;

	lsu_align u_align (
		.cmd        (cmd_q),
		.req_fields (req_fields),
		.misaligned (misaligned),
		.rddata     (bus_rsp.rddata),
		.rdata      (load_data)
	);

	assign access   = req_fields.read | req_fields.write;
	assign bus_done = (state == WAIT) && !bus_rsp.stall;

	// Request flags only in ISSUE, so each access is one bus cycle.
	always_comb begin
		bus_req       = req_fields;
		bus_req.read  = req_fields.read & (state == ISSUE);
		bus_req.write = req_fields.write & (state == ISSUE);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			ack   <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						state <= ISSUE;
					end
				end
				ISSUE: begin
					state <= access ? WAIT : ERROR;
				end
				WAIT: begin
					if (!bus_rsp.stall) begin
						state <= DONE;
						ack   <= 1'b1;
					end
				end
				ERROR: begin
					state <= DONE;
					ack   <= 1'b1;
				end
				DONE: begin
					if (!req) begin
						state <= IDLE;  // Four-phase return to idle.
						ack   <= 1'b0;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			cmd_q <= cmd;
		end
		if (bus_done) begin
			rsp.rdata      <= load_data;
			rsp.misaligned <= 1'b0;
		end
		if (state == ERROR) begin
			rsp.rdata      <= '0;
			rsp.misaligned <= misaligned;
		end
	end

endmodule

// File: verilog/lsu_align.sv
`timescale 1ns/1ps

module lsu_align
	import dbus_pkg::*;
	import lsu_pkg::*;
(
	input  lsu_cmd_t              cmd,
	output dbus_req_t             req_fields,
	output logic                  misaligned,
	input  logic [DATA_WIDTH-1:0] rddata,
	output logic [DATA_WIDTH-1:0] rdata
);

	lsu_size_t                 size;
	logic                      store;
	logic [BYTE_OFF_WIDTH-1:0] offset;
	logic [BE_WIDTH-1:0]       be;
	logic [DATA_WIDTH-1:0]     lane_data;
	logic [DATA_WIDTH-1:0]     shifted;

	assign size   = op_size(cmd.op);
	assign store  = is_store(cmd.op);
	assign offset = cmd.addr[BYTE_OFF_WIDTH-1:0];

	always_comb begin
		case (size)
			SIZE_B:  misaligned = 1'b0;
			SIZE_H:  misaligned = offset[0];
			default: misaligned = |offset;
		endcase
	end

	// Replicate store data so every lane carries it, enables pick the lane.
	always_comb begin
		case (size)
			SIZE_B: begin
				lane_data = {BE_WIDTH{cmd.wdata[7:0]}};
				be        = BE_WIDTH'(1) << offset;
			end
			SIZE_H: begin
				lane_data = {(BE_WIDTH/2){cmd.wdata[15:0]}};
				be        = BE_WIDTH'(3) << offset;
			end
			default: begin
				lane_data = cmd.wdata;
				be        = '1;
			end
		endcase
	end

	always_comb begin
		req_fields.read       = ~store & ~misaligned;
		req_fields.write      = store & ~misaligned;
		req_fields.address    = {cmd.addr[ADDR_WIDTH-1:BYTE_OFF_WIDTH], {BYTE_OFF_WIDTH{1'b0}}};
		req_fields.byteenable = be;
		req_fields.wrdata     = lane_data;
	end

	assign shifted = rddata >> {offset, 3'b000};  // Addressed lane down to bit 0.

	always_comb begin
		case (cmd.op)
			LB:      rdata = {{(DATA_WIDTH-8){shifted[7]}}, shifted[7:0]};
			LBU:     rdata = {{(DATA_WIDTH-8){1'b0}}, shifted[7:0]};
			LH:      rdata = {{(DATA_WIDTH-16){shifted[15]}}, shifted[15:0]};
			LHU:     rdata = {{(DATA_WIDTH-16){1'b0}}, shifted[15:0]};
			LW:      rdata = rddata;
			default: rdata = '0;
		endcase
	end

endmodule

// File: verilog/dbus_mem.sv
`timescale 1ns/1ps

module dbus_mem
	import dbus_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      miss_model_en,
	input  dbus_req_t bus_req,
	output dbus_rsp_t bus_rsp
);

	word_t mem [MEM_WORDS];
	logic [NUM_LINES-1:0] touched;

	logic                  stage_read;
	logic                  stage_write;
	logic [ADDR_WIDTH-1:0] stage_addr;
	logic [BE_WIDTH-1:0]   stage_be;
	word_t                 stage_wrdata;

	logic [WORD_IDX_WIDTH-1:0] word_idx;
	logic [LINE_IDX_WIDTH-1:0] line_idx;
	word_t                     old_word;
	word_t                     merged_word;
	logic                      staged;
	logic                      miss;
	logic                      miss_load;
	logic [MISS_CYCLES-1:0]    stall_cnt;
	logic                      stall;

	assign word_idx = stage_addr[BYTE_OFF_WIDTH +: WORD_IDX_WIDTH];
	assign line_idx = stage_addr[BYTE_OFF_WIDTH + LINE_OFF_WIDTH +: LINE_IDX_WIDTH];
	assign old_word = mem[word_idx];

	assign staged    = stage_read | stage_write;
	assign miss      = staged & ~touched[line_idx];
	assign miss_load = stage_read & miss & miss_model_en & ~(|stall_cnt);
	assign stall     = stage_read & miss_model_en & (miss | (|stall_cnt));

	// Stage flags. The stage holds while a read stalls.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage_read  <= 1'b0;
			stage_write <= 1'b0;
		end else if (!stall) begin
			stage_read  <= bus_req.read;
			stage_write <= bus_req.write;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			stage_addr   <= bus_req.address;
			stage_be     <= bus_req.byteenable;
			stage_wrdata <= bus_req.wrdata;
		end
	end

	// Any staged access marks its line.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			touched <= '0;
		end else if (staged) begin
			touched[line_idx] <= 1'b1;
		end
	end

	// One-hot shift counter drains MISS_CYCLES after the miss cycle.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stall_cnt <= '0;
		end else if (miss_load) begin
			stall_cnt <= {1'b1, {(MISS_CYCLES-1){1'b0}}};
		end else begin
			stall_cnt <= stall_cnt >> 1;
		end
	end

	always_comb begin
		for (int i = 0; i < BE_WIDTH; i++) begin
			merged_word[8*i +: 8] = stage_be[i] ? stage_wrdata[8*i +: 8] : old_word[8*i +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (stage_write) begin
			mem[word_idx] <= merged_word;  // Write at end of staged cycle.
		end
	end

	assign bus_rsp.stall  = stall;
	assign bus_rsp.rddata = old_word;

endmodule

// File: verilog/lsu_pkg.sv
package lsu_pkg;

	typedef enum logic [2:0] {
		LB  = 3'd0,
		LBU = 3'd1,
		LH  = 3'd2,
		LHU = 3'd3,
		LW  = 3'd4,
		SB  = 3'd5,
		SH  = 3'd6,
		SW  = 3'd7
	} lsu_op_t;

	typedef enum logic [1:0] {
		SIZE_B,
		SIZE_H,
		SIZE_W
	} lsu_size_t;

	// Command on the req/ack side.
	typedef struct packed {
		lsu_op_t                        op;
		logic [dbus_pkg::ADDR_WIDTH-1:0] addr;
		logic [dbus_pkg::DATA_WIDTH-1:0] wdata;
	} lsu_cmd_t;

	typedef struct packed {
		logic [dbus_pkg::DATA_WIDTH-1:0] rdata;
		logic                            misaligned;
	} lsu_rsp_t;

	function automatic logic is_store(lsu_op_t op);
		return op inside {SB, SH, SW};
	endfunction

	function automatic lsu_size_t op_size(lsu_op_t op);
		case (op)
			LB, LBU, SB: return SIZE_B;
			LH, LHU, SH: return SIZE_H;
			default:     return SIZE_W;
		endcase
	endfunction

endpackage

// File: verilog/dbus_pkg.sv
package dbus_pkg;

	localparam int DATA_WIDTH  = 32;
	localparam int ADDR_WIDTH  = 32;
	localparam int BE_WIDTH    = DATA_WIDTH / 8;
	localparam int MEM_WORDS   = 2048;
	localparam int LINE_WORDS  = 4;
	localparam int MISS_CYCLES = 5;  // Stall cycles after the miss cycle.

	localparam int NUM_LINES      = MEM_WORDS / LINE_WORDS;
	localparam int BYTE_OFF_WIDTH = $clog2(BE_WIDTH);
	localparam int WORD_IDX_WIDTH = $clog2(MEM_WORDS);
	localparam int LINE_OFF_WIDTH = $clog2(LINE_WORDS);
	localparam int LINE_IDX_WIDTH = $clog2(NUM_LINES);

	typedef logic [DATA_WIDTH-1:0] word_t;

	// One access on the CPU data bus.
	typedef struct packed {
		logic                  read;
		logic                  write;
		logic [ADDR_WIDTH-1:0] address;
		logic [BE_WIDTH-1:0]   byteenable;
		word_t                 wrdata;
	} dbus_req_t;

	typedef struct packed {
		logic  stall;   // Staged read not ready yet.
		word_t rddata;
	} dbus_rsp_t;

endpackage
